//--- phased_array.f
+incdir+.
phased_array_pkg.sv
axil_regs.sv
time_cnt_generator.sv
drive_sequencer.sv
modulation.sv
silencer.sv
pulse_width_encoder.sv
pwm.sv
phased_array_top.sv
tb_clk_gen.sv
tb_phased_array.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f phased_array.f --top-module tb_phased_array -o sim_phased_array

output=$(./obj_dir/sim_phased_array)
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
  exit 0
fi
exit 1

//--- tb_phased_array.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module tb_phased_array;

  localparam int CLK_PERIOD_NS = 40;
  localparam int TEST_COUNT = 6;
  localparam int PERIODS_PER_TEST = 12;
  localparam int MARGIN_PERIODS = 8;
  localparam longint WATCHDOG_NS =
      longint'(TEST_COUNT * PERIODS_PER_TEST + MARGIN_PERIODS) * `PA_CYCLE * CLK_PERIOD_NS;
  localparam int HANDSHAKE_LIMIT = 32;

  logic clk, rst_n;
  logic [`PA_ADDR_W-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [3:0] wstrb;
  phased_array_pkg::axi_resp_t bresp, rresp;
  logic [`PA_DEPTH-1:0] pwm_out;

  int error_count, check_count;
  int cyc;  // Ticks since reset release
  int chk_from, chk_to;  // PWM checked in periods chk_from..chk_to-1
  int cur_tick, cur_per;

  // Host view of the register map
  logic sh_enable;
  phased_array_pkg::intensity_t sh_step;
  logic [3:0] sh_mod_len;
  phased_array_pkg::intensity_t sh_int [`PA_DEPTH];
  phased_array_pkg::phase_t sh_phase [`PA_DEPTH];
  logic [7:0] sh_mod [`PA_MOD_SIZE];
  phased_array_pkg::pulse_width_t sh_pwe [256];

  // Reference pipeline state
  int m_idx;
  int m_int [`PA_DEPTH];
  int m_ph [`PA_DEPTH];
  int nxt_w [`PA_DEPTH];
  int nxt_p [`PA_DEPTH];
  int act_w [`PA_DEPTH];
  int act_p [`PA_DEPTH];

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) clk_gen (
    .clk(clk),
    .rst_n(rst_n)
  );

  phased_array_top i_phased_array_top (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .pwm_out(pwm_out)
  );

  always @(posedge clk) begin
    if (!rst_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  task automatic compare_pwm(input int at_cyc, input logic [`PA_DEPTH-1:0] got,
                             input logic [`PA_DEPTH-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH pwm_out period %0d tick %0d: got %h expected %h",
               at_cyc / `PA_CYCLE, at_cyc % `PA_CYCLE, got, exp);
    end
  endtask

  task automatic compare_data(input string name, input logic [31:0] got,
                              input phased_array_pkg::axi_resp_t got_resp,
                              input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH rdata %s: got %h expected %h", name, got, exp);
    end
    if (got_resp !== phased_array_pkg::RESP_OKAY) begin
      error_count++;
      $display("MISMATCH rresp %s: got %h expected %h", name, got_resp,
               phased_array_pkg::RESP_OKAY);
    end
  endtask

  task automatic compare_resp(input logic [`PA_ADDR_W-1:0] addr,
                              input phased_array_pkg::axi_resp_t got,
                              input phased_array_pkg::axi_resp_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH bresp at %h: got %h expected %h", addr, got, exp);
    end
  endtask

  // Keeps writes clear of the pipeline walk at the period start
  task automatic wait_write_window();
    while (cyc == 0 || (cyc % `PA_CYCLE) < 32 || (cyc % `PA_CYCLE) > 440) @(negedge clk);
  endtask

  task automatic axi_write(input logic [`PA_ADDR_W-1:0] addr, input logic [31:0] data);
    int n;
    wait_write_window();
    awaddr = addr;
    wdata = data;
    wstrb = 4'hF;
    awvalid = 1'b1;
    wvalid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!awready && n < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!awready) begin
      error_count++;
      $display("ERROR: write to %h was never accepted", addr);
      awvalid = 1'b0;
      wvalid = 1'b0;
      return;
    end
    if (!wready) begin
      error_count++;
      $display("ERROR: wready did not rise with awready for write to %h", addr);
    end
    @(negedge clk);  // Handshake taken on the edge before
    awvalid = 1'b0;
    wvalid = 1'b0;
    if (!bvalid) begin
      error_count++;
      $display("ERROR: no write response after write to %h", addr);
    end else begin
      compare_resp(addr, bresp, phased_array_pkg::RESP_OKAY);
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`PA_ADDR_W-1:0] addr, output logic [31:0] data,
                          output phased_array_pkg::axi_resp_t resp);
    int n;
    data = '0;
    resp = phased_array_pkg::RESP_SLVERR;
    araddr = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!arready && n < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!arready) begin
      error_count++;
      $display("ERROR: read from %h was never accepted", addr);
      arvalid = 1'b0;
      return;
    end
    @(negedge clk);  // Handshake taken on the edge before
    arvalid = 1'b0;
    if (!rvalid) begin
      error_count++;
      $display("ERROR: no read data after read from %h", addr);
      return;
    end
    data = rdata;
    resp = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_drive_word(input int c, input logic [31:0] word);
    axi_write(`PA_DRIVE_BASE + 12'(4 * c), word);
    sh_int[c] = word[7:0];
    sh_phase[c] = word[15:8];
  endtask

  task automatic set_drive(input int c, input phased_array_pkg::intensity_t i,
                           input phased_array_pkg::phase_t p);
    write_drive_word(c, {16'h0, p, i});
  endtask

  task automatic write_step(input phased_array_pkg::intensity_t s);
    axi_write(`PA_REG_STEP, {24'h0, s});
    sh_step = s;
  endtask

  task automatic write_ctrl(input logic en);
    axi_write(`PA_REG_CTRL, {31'h0, en});
    sh_enable = en;
  endtask

  task automatic write_mod_len(input logic [3:0] len);
    axi_write(`PA_REG_MOD_LEN, {28'h0, len});
    sh_mod_len = len;
  endtask

  task automatic write_mod_entry(input int k, input logic [7:0] v);
    axi_write(`PA_MOD_BASE + 12'(4 * k), {24'h0, v});
    sh_mod[k] = v;
  endtask

  task automatic write_pwe_entry(input int k, input phased_array_pkg::pulse_width_t w);
    axi_write(`PA_PWE_BASE + 12'(4 * k), {23'h0, w});
    sh_pwe[k] = w;
  endtask

  // Rounded-up square law with code 255 at a full half period
  function automatic phased_array_pkg::pulse_width_t pwe_curve(input int k);
    if (k == 255) return 9'd256;
    return 9'((k * k + 255) / 256);
  endfunction

  // One period of modulation, silencer and encoder for all channels
  task automatic model_step(input int per);
    int c, tgt_i, tgt_p, up, step;
    step = int'(sh_step);
    if (per > 0) m_idx = (m_idx >= int'(sh_mod_len)) ? 0 : m_idx + 1;
    for (c = 0; c < `PA_DEPTH; c++) begin
      tgt_i = (int'(sh_int[c]) * (int'(sh_mod[m_idx]) + 1)) / 256;
      tgt_p = int'(sh_phase[c]);
      if (tgt_i - m_int[c] > step) m_int[c] = m_int[c] + step;
      else if (m_int[c] - tgt_i > step) m_int[c] = m_int[c] - step;
      else m_int[c] = tgt_i;
      up = (tgt_p - m_ph[c] + 256) % 256;
      if (up <= 128) m_ph[c] = (up <= step) ? tgt_p : (m_ph[c] + step) % 256;
      else m_ph[c] = (256 - up <= step) ? tgt_p : (m_ph[c] - step + 256) % 256;
      nxt_w[c] = int'(sh_pwe[m_int[c]]);
      nxt_p[c] = m_ph[c];
    end
  endtask

  function automatic logic [`PA_DEPTH-1:0] expected_pwm(input int tick);
    logic [`PA_DEPTH-1:0] v;
    int c, rise, offset;
    v = '0;
    for (c = 0; c < `PA_DEPTH; c++) begin
      rise = (2 * act_p[c] - act_w[c] / 2 + `PA_CYCLE) % `PA_CYCLE;
      offset = (tick - rise + `PA_CYCLE) % `PA_CYCLE;
      v[c] = sh_enable && (offset < act_w[c]);
    end
    return v;
  endfunction

  always @(negedge clk) begin
    if (cyc > 0) begin
      cur_tick = cyc % `PA_CYCLE;
      cur_per = cyc / `PA_CYCLE;
      if (cur_tick == 0) begin
        act_w = nxt_w;  // New set shows from tick 0
        act_p = nxt_p;
      end
      if (cur_tick == 1) model_step(cur_per);
      if (cur_per >= chk_from && cur_per < chk_to)
        compare_pwm(cyc, pwm_out, expected_pwm(cur_tick));
    end
  end

  // Settings written now first shape the period after next
  task automatic run_checked(input int periods);
    int p0;
    p0 = cyc / `PA_CYCLE;
    chk_from = p0 + 2;
    chk_to = p0 + 2 + periods;
    wait (cyc >= chk_to * `PA_CYCLE);
    @(negedge clk);
  endtask

  task automatic test_register_readback();
    logic [31:0] words [`PA_DEPTH];
    logic [31:0] got;
    phased_array_pkg::axi_resp_t resp;
    phased_array_pkg::intensity_t step;
    logic [3:0] len;
    int c;
    $display("Test: register read-back");
    step = 8'($urandom);
    len = 4'($urandom);
    for (c = 0; c < `PA_DEPTH; c++) begin
      words[c] = $urandom;
      write_drive_word(c, words[c]);
    end
    write_step(step);
    write_mod_len(len);
    for (c = 0; c < `PA_DEPTH; c++) begin
      axi_read(`PA_DRIVE_BASE + 12'(4 * c), got, resp);
      compare_data($sformatf("drive word %0d", c), got, resp, {16'h0, words[c][15:0]});
    end
    axi_read(`PA_REG_STEP, got, resp);
    compare_data("step", got, resp, {24'h0, step});
    axi_read(`PA_REG_MOD_LEN, got, resp);
    compare_data("mod length", got, resp, {28'h0, len});
    axi_read(`PA_REG_CTRL, got, resp);
    compare_data("control", got, resp, 32'h0);
    axi_read(`PA_MOD_BASE + 12'h004, got, resp);
    compare_data("mod table", got, resp, 32'h0);
    axi_read(`PA_PWE_BASE + 12'h008, got, resp);
    compare_data("encoder table", got, resp, 32'h0);
    axi_read(`PA_PWE_BASE + 12'h3FC, got, resp);
    compare_data("encoder table end", got, resp, 32'h0);
  endtask

  task automatic test_output_enable();
    int c, k;
    $display("Test: output enable");
    write_ctrl(1'b0);
    write_step(8'd255);
    write_mod_len(4'd0);
    for (k = 0; k < 256; k++) write_pwe_entry(k, 9'(k));
    for (c = 0; c < `PA_DEPTH; c++) set_drive(c, 8'd255, 8'(c * 32));
    run_checked(1);  // Still disabled
    write_ctrl(1'b1);
    run_checked(2);
  endtask

  task automatic test_phase_placement();
    int c;
    $display("Test: phase placement");
    set_drive(0, 8'd128, 8'd0);  // Rises before tick 0
    set_drive(1, 8'd128, 8'd255);
    for (c = 2; c < `PA_DEPTH; c++) set_drive(c, 8'd128, 8'($urandom));
    run_checked(2);
  endtask

  task automatic test_silencer();
    int c;
    $display("Test: silencer");
    write_step(8'd255);
    for (c = 0; c < `PA_DEPTH; c++) set_drive(c, 8'd0, 8'd0);
    run_checked(1);
    write_step(8'd16);
    for (c = 0; c < `PA_DEPTH; c++)
      set_drive(c, 8'd200, (c == 7) ? 8'd128 : 8'(c * 37));  // Channel 7 sits on the tie
    run_checked(14);
  endtask

  task automatic test_modulation();
    int c;
    $display("Test: modulation");
    write_step(8'd255);
    for (c = 0; c < `PA_DEPTH; c++) set_drive(c, 8'd200, 8'd64);
    write_mod_entry(0, 8'd255);
    write_mod_entry(1, 8'd127);
    write_mod_entry(2, 8'd63);
    write_mod_entry(3, 8'd0);
    write_mod_len(4'd3);
    run_checked(8);
  endtask

  task automatic test_encoder_table();
    int c, k;
    $display("Test: encoder table");
    write_mod_len(4'd0);
    for (k = 0; k < 256; k++) write_pwe_entry(k, pwe_curve(k));
    set_drive(0, 8'd0, 8'($urandom));
    set_drive(1, 8'd255, 8'($urandom));
    for (c = 2; c < `PA_DEPTH; c++) set_drive(c, 8'($urandom), 8'($urandom));
    run_checked(2);
  endtask

  initial begin
    int c, k;
    void'($urandom(48247));
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    error_count = 0;
    check_count = 0;
    chk_from = 0;
    chk_to = 0;
    sh_enable = 1'b0;
    sh_step = '0;
    sh_mod_len = '0;
    m_idx = 0;
    for (c = 0; c < `PA_DEPTH; c++) begin
      sh_int[c] = '0;
      sh_phase[c] = '0;
      m_int[c] = 0;
      m_ph[c] = 0;
      nxt_w[c] = 0;
      nxt_p[c] = 0;
      act_w[c] = 0;
      act_p[c] = 0;
    end
    for (k = 0; k < `PA_MOD_SIZE; k++) sh_mod[k] = 8'hFF;  // Reset table passes through
    for (k = 0; k < 256; k++) sh_pwe[k] = '0;
    @(posedge rst_n);
    @(negedge clk);
    test_register_readback();
    test_output_enable();
    test_phase_placement();
    test_silencer();
    test_modulation();
    test_encoder_table();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps
module tb_clk_gen #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Released on a falling edge like every other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- phased_array_top.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module phased_array_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`PA_ADDR_W-1:0]        awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output phased_array_pkg::axi_resp_t  bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`PA_ADDR_W-1:0]        araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [31:0]                  rdata,
  output phased_array_pkg::axi_resp_t  rresp,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [`PA_DEPTH-1:0]         pwm_out
);

  logic out_enable;
  phased_array_pkg::intensity_t silencer_step;
  logic [3:0] mod_len;
  phased_array_pkg::intensity_t drive_intensity [`PA_DEPTH];
  phased_array_pkg::phase_t drive_phase [`PA_DEPTH];
  logic mod_we;
  logic [3:0] mod_addr;
  logic [7:0] mod_wdata;
  logic pwe_we;
  logic [7:0] pwe_addr;
  phased_array_pkg::pulse_width_t pwe_wdata;

  phased_array_pkg::time_cnt_t time_cnt;
  logic update;

  phased_array_pkg::intensity_t intensity, intensity_m, intensity_s;
  phased_array_pkg::phase_t phase, phase_m, phase_s, phase_e;
  phased_array_pkg::pulse_width_t pulse_width_e;
  logic dout_valid, dout_valid_m, dout_valid_s, dout_valid_e;

  axil_regs axil_regs (
      .clk(clk),
      .rst_n(rst_n),
      .awaddr(awaddr),
      .awvalid(awvalid),
      .awready(awready),
      .wdata(wdata),
      .wstrb(wstrb),
      .wvalid(wvalid),
      .wready(wready),
      .bresp(bresp),
      .bvalid(bvalid),
      .bready(bready),
      .araddr(araddr),
      .arvalid(arvalid),
      .arready(arready),
      .rdata(rdata),
      .rresp(rresp),
      .rvalid(rvalid),
      .rready(rready),
      .out_enable(out_enable),
      .silencer_step(silencer_step),
      .mod_len(mod_len),
      .drive_intensity(drive_intensity),
      .drive_phase(drive_phase),
      .mod_we(mod_we),
      .mod_addr(mod_addr),
      .mod_wdata(mod_wdata),
      .pwe_we(pwe_we),
      .pwe_addr(pwe_addr),
      .pwe_wdata(pwe_wdata)
  );

  time_cnt_generator time_cnt_generator (
      .clk(clk),
      .rst_n(rst_n),
      .time_cnt(time_cnt),
      .update(update)
  );

  drive_sequencer drive_sequencer (
      .clk(clk),
      .rst_n(rst_n),
      .update(update),
      .drive_intensity(drive_intensity),
      .drive_phase(drive_phase),
      .intensity(intensity),
      .phase(phase),
      .dout_valid(dout_valid)
  );

  modulation modulation (
      .clk(clk),
      .rst_n(rst_n),
      .update(update),
      .mod_len(mod_len),
      .mod_we(mod_we),
      .mod_addr(mod_addr),
      .mod_wdata(mod_wdata),
      .din_valid(dout_valid),
      .intensity_in(intensity),
      .phase_in(phase),
      .intensity_out(intensity_m),
      .phase_out(phase_m),
      .dout_valid(dout_valid_m)
  );

  silencer silencer (
      .clk(clk),
      .rst_n(rst_n),
      .silencer_step(silencer_step),
      .din_valid(dout_valid_m),
      .intensity_in(intensity_m),
      .phase_in(phase_m),
      .intensity_out(intensity_s),
      .phase_out(phase_s),
      .dout_valid(dout_valid_s)
  );

  pulse_width_encoder pulse_width_encoder (
      .clk(clk),
      .pwe_we(pwe_we),
      .pwe_addr(pwe_addr),
      .pwe_wdata(pwe_wdata),
      .din_valid(dout_valid_s),
      .intensity_in(intensity_s),
      .phase_in(phase_s),
      .pulse_width_out(pulse_width_e),
      .phase_out(phase_e),
      .dout_valid(dout_valid_e)
  );

  pwm pwm (
      .clk(clk),
      .rst_n(rst_n),
      .time_cnt(time_cnt),
      .update(update),
      .out_enable(out_enable),
      .din_valid(dout_valid_e),
      .pulse_width(pulse_width_e),
      .phase(phase_e),
      .pwm_out(pwm_out)
  );

endmodule

//--- pwm.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module pwm (
  input  logic                            clk,
  input  logic                            rst_n,
  input  phased_array_pkg::time_cnt_t     time_cnt,
  input  logic                            update,
  input  logic                            out_enable,
  input  logic                            din_valid,
  input  phased_array_pkg::pulse_width_t  pulse_width,
  input  phased_array_pkg::phase_t        phase,
  output logic [`PA_DEPTH-1:0]            pwm_out
);

  localparam int CH_W = $clog2(`PA_DEPTH);

  logic [CH_W-1:0] ch;
  phased_array_pkg::pulse_width_t pend_w [`PA_DEPTH];
  phased_array_pkg::pulse_width_t act_w [`PA_DEPTH];
  phased_array_pkg::phase_t pend_p [`PA_DEPTH];
  phased_array_pkg::phase_t act_p [`PA_DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ch <= '0;
      for (int c = 0; c < `PA_DEPTH; c++) begin
        pend_w[c] <= '0;
        pend_p[c] <= '0;
        act_w[c] <= '0;
        act_p[c] <= '0;
      end
    end else begin
      if (din_valid) begin
        pend_w[ch] <= pulse_width;
        pend_p[ch] <= phase;
        ch <= (ch == CH_W'(`PA_DEPTH - 1)) ? '0 : ch + 1'b1;
      end
      if (update) begin
        for (int c = 0; c < `PA_DEPTH; c++) begin
          act_w[c] <= pend_w[c];
          act_p[c] <= pend_p[c];
        end
      end
    end
  end

  for (genvar c = 0; c < `PA_DEPTH; c++) begin : g_ch
    phased_array_pkg::pulse_width_t w;
    phased_array_pkg::phase_t p;
    phased_array_pkg::time_cnt_t rise, offset;

    // Tick 0 already sees the new set
    assign w = update ? pend_w[c] : act_w[c];
    assign p = update ? pend_p[c] : act_p[c];
    assign rise = {p, 1'b0} - (w >> 1);  // Pulse centred on twice the phase
    assign offset = time_cnt - rise;
    assign pwm_out[c] = out_enable & (offset < w);
  end

endmodule

//--- pulse_width_encoder.sv
`timescale 1ns/10ps
module pulse_width_encoder (
  input  logic                            clk,
  input  logic                            pwe_we,
  input  logic [7:0]                      pwe_addr,
  input  phased_array_pkg::pulse_width_t  pwe_wdata,
  input  logic                            din_valid,
  input  phased_array_pkg::intensity_t    intensity_in,
  input  phased_array_pkg::phase_t        phase_in,
  output phased_array_pkg::pulse_width_t  pulse_width_out,
  output phased_array_pkg::phase_t        phase_out,
  output logic                            dout_valid
);

  // One entry per intensity code
  phased_array_pkg::pulse_width_t pwe_ram [256];

  always_ff @(posedge clk) begin
    if (pwe_we) pwe_ram[pwe_addr] <= pwe_wdata;
  end

  always_ff @(posedge clk) begin
    dout_valid <= din_valid;
    pulse_width_out <= pwe_ram[intensity_in];  // Registered read
    phase_out <= phase_in;
  end

  a_width_in_range: assert property (
    @(posedge clk) pwe_we |-> pwe_wdata <= 9'd256
  );

endmodule

//--- silencer.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module silencer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  phased_array_pkg::intensity_t  silencer_step,
  input  logic                          din_valid,
  input  phased_array_pkg::intensity_t  intensity_in,
  input  phased_array_pkg::phase_t      phase_in,
  output phased_array_pkg::intensity_t  intensity_out,
  output phased_array_pkg::phase_t      phase_out,
  output logic                          dout_valid
);

  localparam int CH_W = $clog2(`PA_DEPTH);

  phased_array_pkg::intensity_t cur_int [`PA_DEPTH];
  phased_array_pkg::phase_t cur_phase [`PA_DEPTH];
  logic [CH_W-1:0] ch;  // Arrival order
  phased_array_pkg::intensity_t int_now, int_next;
  phased_array_pkg::phase_t ph_now, ph_next, ph_up, ph_down;

  assign int_now = cur_int[ch];
  assign ph_now = cur_phase[ch];
  assign ph_up = phase_in - ph_now;  // Distance going up, mod 256
  assign ph_down = ph_now - phase_in;

  always_comb begin
    if (intensity_in >= int_now) begin
      if (intensity_in - int_now <= silencer_step) int_next = intensity_in;
      else int_next = int_now + silencer_step;
    end else begin
      if (int_now - intensity_in <= silencer_step) int_next = intensity_in;
      else int_next = int_now - silencer_step;
    end
  end

  // Half-circle tie resolves upward
  always_comb begin
    if (ph_up <= 8'd128) begin
      if (ph_up <= silencer_step) ph_next = phase_in;
      else ph_next = ph_now + silencer_step;
    end else begin
      if (ph_down <= silencer_step) ph_next = phase_in;
      else ph_next = ph_now - silencer_step;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ch <= '0;
      dout_valid <= 1'b0;
      for (int c = 0; c < `PA_DEPTH; c++) begin
        cur_int[c] <= '0;
        cur_phase[c] <= '0;
      end
    end else begin
      dout_valid <= din_valid;
      if (din_valid) begin
        cur_int[ch] <= int_next;
        cur_phase[ch] <= ph_next;
        ch <= (ch == CH_W'(`PA_DEPTH - 1)) ? '0 : ch + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (din_valid) begin
      intensity_out <= int_next;
      phase_out <= ph_next;
    end
  end

endmodule

//--- modulation.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module modulation (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          update,
  input  logic [3:0]                    mod_len,
  input  logic                          mod_we,
  input  logic [3:0]                    mod_addr,
  input  logic [7:0]                    mod_wdata,
  input  logic                          din_valid,
  input  phased_array_pkg::intensity_t  intensity_in,
  input  phased_array_pkg::phase_t      phase_in,
  output phased_array_pkg::intensity_t  intensity_out,
  output phased_array_pkg::phase_t      phase_out,
  output logic                          dout_valid
);

  logic [7:0] mod_table [`PA_MOD_SIZE];
  logic [3:0] mod_idx;
  logic started;
  logic [16:0] scaled;

  // Sample 255 gives a factor of exactly one
  assign scaled = intensity_in * ({1'b0, mod_table[mod_idx]} + 9'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mod_idx <= '0;
      started <= 1'b0;
      dout_valid <= 1'b0;
      for (int k = 0; k < `PA_MOD_SIZE; k++) mod_table[k] <= 8'hFF;  // Pass-through
    end else begin
      dout_valid <= din_valid;
      if (mod_we) mod_table[mod_addr] <= mod_wdata;
      if (update) begin
        if (!started) started <= 1'b1;  // First period keeps sample 0
        else mod_idx <= (mod_idx >= mod_len) ? '0 : mod_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (din_valid) begin
      intensity_out <= scaled[15:8];
      phase_out <= phase_in;
    end
  end

endmodule

//--- drive_sequencer.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module drive_sequencer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          update,
  input  phased_array_pkg::intensity_t  drive_intensity [`PA_DEPTH],
  input  phased_array_pkg::phase_t      drive_phase [`PA_DEPTH],
  output phased_array_pkg::intensity_t  intensity,
  output phased_array_pkg::phase_t      phase,
  output logic                          dout_valid
);

  localparam int CH_W = $clog2(`PA_DEPTH);

  logic [CH_W-1:0] ch;  // Next channel to emit
  logic active;
  logic [CH_W-1:0] sel;

  assign sel = update ? '0 : ch;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ch <= '0;
      active <= 1'b0;
      dout_valid <= 1'b0;
    end else if (update || active) begin
      dout_valid <= 1'b1;
      active <= (sel != CH_W'(`PA_DEPTH - 1));
      ch <= sel + 1'b1;
    end else begin
      dout_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (update || active) begin
      intensity <= drive_intensity[sel];
      phase <= drive_phase[sel];
    end
  end

  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n) update |-> !active
  );

endmodule

//--- time_cnt_generator.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module time_cnt_generator (
  input  logic                          clk,
  input  logic                          rst_n,
  output phased_array_pkg::time_cnt_t   time_cnt,
  output logic                          update
);

  // Time starts at reset, no external alignment
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      time_cnt <= '0;
    end else if (time_cnt == `PA_CYCLE - 1) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 1'b1;
    end
  end

  assign update = (time_cnt == '0);  // Period start

endmodule

//--- axil_regs.sv
`timescale 1ns/10ps
`include "phased_array_cfg.svh"
module axil_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [`PA_ADDR_W-1:0]            awaddr,
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [31:0]                      wdata,
  input  logic [3:0]                       wstrb,
  input  logic                             wvalid,
  output logic                             wready,
  output phased_array_pkg::axi_resp_t      bresp,
  output logic                             bvalid,
  input  logic                             bready,
  input  logic [`PA_ADDR_W-1:0]            araddr,
  input  logic                             arvalid,
  output logic                             arready,
  output logic [31:0]                      rdata,
  output phased_array_pkg::axi_resp_t      rresp,
  output logic                             rvalid,
  input  logic                             rready,
  output logic                             out_enable,
  output phased_array_pkg::intensity_t     silencer_step,
  output logic [3:0]                       mod_len,
  output phased_array_pkg::intensity_t     drive_intensity [`PA_DEPTH],
  output phased_array_pkg::phase_t         drive_phase [`PA_DEPTH],
  output logic                             mod_we,
  output logic [3:0]                       mod_addr,
  output logic [7:0]                       mod_wdata,
  output logic                             pwe_we,
  output logic [7:0]                       pwe_addr,
  output phased_array_pkg::pulse_width_t   pwe_wdata
);

  localparam int CH_W = $clog2(`PA_DEPTH);

  logic wr_fire, rd_fire;
  logic is_drv_w, is_drv_r;
  logic [CH_W-1:0] wr_idx, rd_idx;
  logic [31:0] rd_word;

  assign wready = awready;  // Address and data taken together
  assign wr_fire = awready & awvalid & wvalid;
  assign rd_fire = arready & arvalid;
  assign bresp = phased_array_pkg::RESP_OKAY;
  assign rresp = phased_array_pkg::RESP_OKAY;

  assign is_drv_w = ((awaddr & 12'hF00) == `PA_DRIVE_BASE) && (awaddr[7:2] < `PA_DEPTH);
  assign is_drv_r = ((araddr & 12'hF00) == `PA_DRIVE_BASE) && (araddr[7:2] < `PA_DEPTH);
  assign wr_idx = awaddr[2 +: CH_W];
  assign rd_idx = araddr[2 +: CH_W];

  // Table write ports act on the handshake edge
  assign mod_we = wr_fire && ((awaddr & 12'hF00) == `PA_MOD_BASE) &&
                  (awaddr[7:2] < `PA_MOD_SIZE) && wstrb[0];
  assign mod_addr = awaddr[5:2];
  assign mod_wdata = wdata[7:0];
  assign pwe_we = wr_fire && ((awaddr & 12'hC00) == `PA_PWE_BASE) && (wstrb[1:0] == 2'b11);
  assign pwe_addr = awaddr[9:2];
  assign pwe_wdata = wdata[8:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      bvalid <= 1'b0;
      arready <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      awready <= !awready && awvalid && wvalid && !bvalid;
      if (wr_fire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      arready <= !arready && arvalid && !rvalid;
      if (rd_fire) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_enable <= 1'b0;
      silencer_step <= '0;
      mod_len <= '0;
      for (int c = 0; c < `PA_DEPTH; c++) begin
        drive_intensity[c] <= '0;
        drive_phase[c] <= '0;
      end
    end else if (wr_fire) begin
      if (awaddr == `PA_REG_CTRL && wstrb[0]) out_enable <= wdata[0];
      if (awaddr == `PA_REG_STEP && wstrb[0]) silencer_step <= wdata[7:0];
      if (awaddr == `PA_REG_MOD_LEN && wstrb[0]) mod_len <= wdata[3:0];
      if (is_drv_w) begin
        if (wstrb[0]) drive_intensity[wr_idx] <= wdata[7:0];
        if (wstrb[1]) drive_phase[wr_idx] <= wdata[15:8];
      end
    end
  end

  // Tables are write only
  always_comb begin
    rd_word = '0;
    if (araddr == `PA_REG_CTRL) rd_word[0] = out_enable;
    else if (araddr == `PA_REG_STEP) rd_word[7:0] = silencer_step;
    else if (araddr == `PA_REG_MOD_LEN) rd_word[3:0] = mod_len;
    else if (is_drv_r) rd_word[15:0] = {drive_phase[rd_idx], drive_intensity[rd_idx]};
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata <= rd_word;
  end

  a_bvalid_after_write: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(bvalid) |-> $past(wr_fire)
  );

  // Read data holds while the response waits
  a_rvalid_held: assert property (
    @(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid && $stable(rdata)
  );

endmodule

//--- phased_array_pkg.sv
package phased_array_pkg;

  // Emission amplitude, 0 is off
  typedef logic [7:0] intensity_t;

  // 256 steps span one carrier period
  typedef logic [7:0] phase_t;

  // High time in ticks, 0 to 256
  typedef logic [8:0] pulse_width_t;

  typedef logic [8:0] time_cnt_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

endpackage

//--- phased_array_cfg.svh
`ifndef PHASED_ARRAY_CFG_SVH
`define PHASED_ARRAY_CFG_SVH

`define PA_DEPTH 8
`define PA_CYCLE 512
`define PA_MOD_SIZE 16
`define PA_ADDR_W 12

// Host register map
`define PA_REG_CTRL 12'h000
`define PA_REG_STEP 12'h004
`define PA_REG_MOD_LEN 12'h008
`define PA_MOD_BASE 12'h100
`define PA_DRIVE_BASE 12'h200
`define PA_PWE_BASE 12'h400

`endif
